//--- wb_subsys.f
wb_subsys_pkg.sv
wb_subsys_if.sv
regfile.sv
lsu.sv
wb_stage.sv
issue_exec.sv
wb_subsys_top.sv
wb_subsys_tb.sv

//--- Makefile
# Verilator simulation of the writeback subsystem

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -j 0 --top-module wb_subsys_tb \
		-f wb_subsys.f -o wb_subsys_sim
	./obj_dir/wb_subsys_sim 2>&1 | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

//--- wb_subsys_tb.sv
/*
 * Testbench for the writeback subsystem with a random instruction stream, a reference
 * model of registers and memory, and in-order completion and final state checks
 */

`timescale 1ns/1ps

module wb_subsys_tb;
  import wb_subsys_pkg::*;

  localparam int SEED           = 89019;
  localparam int NUM_INSTR      = 300;
  localparam int TIMEOUT_CYCLES = 100;

  logic              clk_i = 1'b0;
  logic              rst_ni;
  logic              instr_valid_i;
  op_e               op_i;
  logic [REG_AW-1:0] rd_i;
  logic [REG_AW-1:0] rs1_i;
  logic [REG_AW-1:0] rs2_i;
  logic [XLEN-1:0]   imm_i;
  logic [XLEN-1:0]   pc_i;
  logic              instr_ready_o;
  logic              instr_done_o;
  logic [XLEN-1:0]   pc_wb_o;
  logic [REG_AW-1:0] dbg_raddr_i;
  logic [XLEN-1:0]   dbg_rdata_o;

  // Architectural state of the reference model
  logic [XLEN-1:0] model_regs [NUM_REGS];
  logic [XLEN-1:0] model_mem  [MEM_WORDS];
  // Pcs of accepted instructions that have not completed yet in issue order
  logic [XLEN-1:0] exp_pc_q [$];
  logic [XLEN-1:0] next_pc;

  always #5 clk_i = ~clk_i;

  wb_subsys_top wb_subsys_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .op_i          (op_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .imm_i         (imm_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .instr_done_o  (instr_done_o),
    .pc_wb_o       (pc_wb_o),
    .dbg_raddr_i   (dbg_raddr_i),
    .dbg_rdata_o   (dbg_rdata_o)
  );

  task automatic abort_run();
    $display("TEST FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [XLEN-1:0] actual,
                             input logic [XLEN-1:0] expected);
    if (actual !== expected) begin
      $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
      abort_run();
    end
  endtask

  // Applies one instruction to the model state, in acceptance order
  task automatic model_execute(input op_e op, input logic [REG_AW-1:0] rd,
                               input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2,
                               input logic [XLEN-1:0] imm);
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] result;
    logic            writes_rd;
    a         = model_regs[rs1];
    b         = model_regs[rs2];
    addr      = a + imm;
    writes_rd = 1'b1;
    case (op)
      OP_ADD:  result = a + b;
      OP_SUB:  result = a - b;
      OP_AND:  result = a & b;
      OP_OR:   result = a | b;
      OP_XOR:  result = a ^ b;
      OP_ADDI: result = a + imm;
      OP_LW:   result = model_mem[addr[MEM_AW+1:2]];
      default: begin
        // Store writes the word picked by address bits 5 to 2
        model_mem[addr[MEM_AW+1:2]] = b;
        result    = '0;
        writes_rd = 1'b0;
      end
    endcase
    if (writes_rd && (rd != '0)) begin
      model_regs[rd] = result;
    end
  endtask

  // Holds the instruction from a falling edge until the rising edge that accepts it
  task automatic issue_instr(input op_e op, input logic [REG_AW-1:0] rd,
                             input logic [REG_AW-1:0] rs1, input logic [REG_AW-1:0] rs2,
                             input logic [XLEN-1:0] imm);
    int waited;
    waited = 0;
    @(negedge clk_i);
    instr_valid_i = 1'b1;
    op_i          = op;
    rd_i          = rd;
    rs1_i         = rs1;
    rs2_i         = rs2;
    imm_i         = imm;
    pc_i          = next_pc;
    @(posedge clk_i);
    while (!instr_ready_o) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("** Error: timeout, instruction at pc 0x%08h was never accepted", next_pc);
        abort_run();
      end
      @(posedge clk_i);
    end
    model_execute(op, rd, rs1, rs2, imm);
    exp_pc_q.push_back(next_pc);
    next_pc = next_pc + 32'd4;
  endtask

  task automatic issue_random_instr();
    op_e               op;
    logic [REG_AW-1:0] rd;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   imm;
    op  = op_e'($urandom_range(0, 7));
    rd  = REG_AW'($urandom_range(0, 7));
    rs1 = REG_AW'($urandom_range(0, 7));
    rs2 = REG_AW'($urandom_range(0, 7));
    // Immediate stays inside the byte range of the LSU memory
    imm = $urandom_range(0, MEM_WORDS * 4 - 1);
    issue_instr(op, rd, rs1, rs2, imm);
  endtask

  task automatic idle_cycles(input int n);
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    repeat (n) @(negedge clk_i);
  endtask

  task automatic drain_pending();
    int waited;
    waited = 0;
    @(negedge clk_i);
    instr_valid_i = 1'b0;
    while (exp_pc_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT_CYCLES) begin
        $display("** Error: timeout, %0d instructions never completed", exp_pc_q.size());
        abort_run();
      end
      @(negedge clk_i);
    end
  endtask

  // Reads every register through the debug port and compares with the model
  task automatic check_registers();
    for (int r = 0; r < NUM_REGS; r++) begin
      @(negedge clk_i);
      dbg_raddr_i = REG_AW'(r);
      @(posedge clk_i);
      check_value($sformatf("dbg_rdata_o[x%0d]", r), dbg_rdata_o, model_regs[r]);
    end
  endtask

  // Each completion must belong to the oldest pending instruction
  always @(posedge clk_i) begin : done_monitor
    logic [XLEN-1:0] exp_pc;
    if (rst_ni && instr_done_o) begin
      if (exp_pc_q.size() == 0) begin
        $display("** Error: instr_done_o pulsed with no instruction pending");
        abort_run();
      end else begin
        exp_pc = exp_pc_q.pop_front();
        check_value("pc_wb_o", pc_wb_o, exp_pc);
      end
    end
  end

  initial begin
    void'($urandom(SEED));
    rst_ni        = 1'b0;
    instr_valid_i = 1'b0;
    op_i          = OP_ADD;
    rd_i          = '0;
    rs1_i         = '0;
    rs2_i         = '0;
    imm_i         = '0;
    pc_i          = '0;
    dbg_raddr_i   = '0;
    next_pc       = '0;
    for (int i = 0; i < NUM_REGS; i++) begin
      model_regs[i] = '0;
    end
    // LSU memory is cleared by reset
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end

    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_value("instr_ready_o", XLEN'(instr_ready_o), XLEN'(1'b1));
    check_value("instr_done_o", XLEN'(instr_done_o), XLEN'(1'b0));

    // Dense random stream with occasional idle gaps
    for (int n = 0; n < NUM_INSTR; n++) begin
      issue_random_instr();
      if ($urandom_range(0, 2) == 0) begin
        idle_cycles(int'($urandom_range(1, 4)));
      end
    end

    // Load each memory word into x8 to x23 so the register check covers memory
    for (int i = 0; i < MEM_WORDS; i++) begin
      issue_instr(OP_LW, REG_AW'(8 + i), '0, '0, XLEN'(i * 4));
    end

    drain_pending();
    check_registers();
    $display("TEST PASSED");
    $finish;
  end

endmodule

//--- wb_subsys_top.sv
/*
 * Top level of the writeback subsystem with execute, LSU, writeback and regfile
 */

`timescale 1ns/1ps

module wb_subsys_top (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             instr_valid_i,
  input  wb_subsys_pkg::op_e               op_i,
  input  logic [wb_subsys_pkg::REG_AW-1:0] rd_i,
  input  logic [wb_subsys_pkg::REG_AW-1:0] rs1_i,
  input  logic [wb_subsys_pkg::REG_AW-1:0] rs2_i,
  input  logic [wb_subsys_pkg::XLEN-1:0]   imm_i,
  input  logic [wb_subsys_pkg::XLEN-1:0]   pc_i,
  output logic                             instr_ready_o,
  output logic                             instr_done_o,
  output logic [wb_subsys_pkg::XLEN-1:0]   pc_wb_o,
  input  logic [wb_subsys_pkg::REG_AW-1:0] dbg_raddr_i,
  output logic [wb_subsys_pkg::XLEN-1:0]   dbg_rdata_o
);
  import wb_subsys_pkg::*;

  // Operand read between execute and the register file
  logic [REG_AW-1:0] rs1_raddr;
  logic [REG_AW-1:0] rs2_raddr;
  logic [XLEN-1:0]   rs1_rdata;
  logic [XLEN-1:0]   rs2_rdata;

  // LSU status and response
  logic              lsu_busy;
  logic [XLEN-1:0]   rf_wdata_lsu;
  logic              rf_we_lsu;
  logic              lsu_resp_valid;

  // Single register file write port driven by writeback
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;
  logic              rf_we;

  ex_wb_if   ex_wb ();
  lsu_req_if lsu_req ();
  wb_hz_if   hz ();

  issue_exec issue_exec_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .instr_valid_i (instr_valid_i),
    .op_i          (op_i),
    .rd_i          (rd_i),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .imm_i         (imm_i),
    .pc_i          (pc_i),
    .instr_ready_o (instr_ready_o),
    .rs1_raddr_o   (rs1_raddr),
    .rs2_raddr_o   (rs2_raddr),
    .rs1_rdata_i   (rs1_rdata),
    .rs2_rdata_i   (rs2_rdata),
    .lsu_busy_i    (lsu_busy),
    .ex_wb         (ex_wb.ex),
    .lsu_req       (lsu_req.ex),
    .hz            (hz.ex)
  );

  lsu lsu_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lsu_req          (lsu_req.lsu),
    .busy_o           (lsu_busy),
    .rf_wdata_lsu_o   (rf_wdata_lsu),
    .rf_we_lsu_o      (rf_we_lsu),
    .lsu_resp_valid_o (lsu_resp_valid)
  );

  wb_stage wb_stage_i (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .ex_wb            (ex_wb.wb),
    .hz               (hz.wb),
    .rf_wdata_lsu_i   (rf_wdata_lsu),
    .rf_we_lsu_i      (rf_we_lsu),
    .lsu_resp_valid_i (lsu_resp_valid),
    .rf_waddr_o       (rf_waddr),
    .rf_wdata_o       (rf_wdata),
    .rf_we_o          (rf_we),
    .pc_wb_o          (pc_wb_o),
    .instr_done_o     (instr_done_o)
  );

  regfile regfile_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .raddr_a_i   (rs1_raddr),
    .rdata_a_o   (rs1_rdata),
    .raddr_b_i   (rs2_raddr),
    .rdata_b_o   (rs2_rdata),
    .dbg_raddr_i (dbg_raddr_i),
    .dbg_rdata_o (dbg_rdata_o),
    .waddr_i     (rf_waddr),
    .wdata_i     (rf_wdata),
    .we_i        (rf_we)
  );

endmodule

//--- issue_exec.sv
/*
 * Issue/execute unit with forwarding, load-use stall, ALU and LSU request routing
 */

`timescale 1ns/1ps

module issue_exec (
  input  logic                                clk_i,
  input  logic                                rst_ni,
  input  logic                                instr_valid_i,
  input  wb_subsys_pkg::op_e                  op_i,
  input  logic [wb_subsys_pkg::REG_AW-1:0]    rd_i,
  input  logic [wb_subsys_pkg::REG_AW-1:0]    rs1_i,
  input  logic [wb_subsys_pkg::REG_AW-1:0]    rs2_i,
  input  logic [wb_subsys_pkg::XLEN-1:0]      imm_i,
  input  logic [wb_subsys_pkg::XLEN-1:0]      pc_i,
  output logic                                instr_ready_o,
  output logic [wb_subsys_pkg::REG_AW-1:0]    rs1_raddr_o,
  output logic [wb_subsys_pkg::REG_AW-1:0]    rs2_raddr_o,
  input  logic [wb_subsys_pkg::XLEN-1:0]      rs1_rdata_i,
  input  logic [wb_subsys_pkg::XLEN-1:0]      rs2_rdata_i,
  input  logic                                lsu_busy_i,
  ex_wb_if.ex                                 ex_wb,
  lsu_req_if.ex                               lsu_req,
  wb_hz_if.ex                                 hz
);
  import wb_subsys_pkg::*;

  logic            uses_rs2;
  logic            is_mem;
  logic            load_use;
  logic            accept;
  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] alu_result;
  wb_instr_type_e  instr_type;
  logic            rf_we;

  // Writeback result overrides the register file when it targets the source
  // Loads are excluded because their data is not known yet
  function automatic logic [XLEN-1:0] fwd_operand(logic [REG_AW-1:0] raddr,
                                                  logic [XLEN-1:0]   rdata);
    logic hit;
    hit = hz.rf_write_wb && !hz.outstanding_load &&
          (hz.rf_waddr_wb != '0) && (hz.rf_waddr_wb == raddr);
    return hit ? hz.rf_wdata_fwd : rdata;
  endfunction

  // Register file is read straight from the held instruction fields
  assign rs1_raddr_o = rs1_i;
  assign rs2_raddr_o = rs2_i;

  assign op_a = fwd_operand(rs1_i, rs1_rdata_i);
  assign op_b = fwd_operand(rs2_i, rs2_rdata_i);

  // Decode source usage, writeback type and the ALU result
  always_comb begin
    uses_rs2   = 1'b1;
    is_mem     = 1'b0;
    instr_type = WB_INSTR_OTHER;
    rf_we      = 1'b1;
    alu_result = op_a + op_b;
    unique case (op_i)
      OP_ADD:  alu_result = op_a + op_b;
      OP_SUB:  alu_result = op_a - op_b;
      OP_AND:  alu_result = op_a & op_b;
      OP_OR:   alu_result = op_a | op_b;
      OP_XOR:  alu_result = op_a ^ op_b;
      OP_ADDI: begin
        uses_rs2   = 1'b0;
        alu_result = op_a + imm_i;
      end
      OP_LW: begin
        // Load data is written by the LSU path in writeback, not from here
        uses_rs2   = 1'b0;
        is_mem     = 1'b1;
        instr_type = WB_INSTR_LOAD;
        rf_we      = 1'b0;
        alu_result = op_a + imm_i;
      end
      OP_SW: begin
        is_mem     = 1'b1;
        instr_type = WB_INSTR_STORE;
        rf_we      = 1'b0;
        alu_result = op_a + imm_i;
      end
      default: begin
        rf_we = 1'b0;
      end
    endcase
  end

  // Stall while a load in writeback still owes the value of a source register
  // Every op reads rs1 while rs2 depends on the op
  assign load_use = hz.outstanding_load && (hz.rf_waddr_wb != '0) &&
                    ((hz.rf_waddr_wb == rs1_i) ||
                     (uses_rs2 && (hz.rf_waddr_wb == rs2_i)));

  assign instr_ready_o = hz.ready_wb && !load_use && (!is_mem || !lsu_busy_i);
  assign accept        = instr_valid_i && instr_ready_o;

  // Every accepted instruction moves into writeback at the accepting edge
  assign ex_wb.en_wb      = accept;
  assign ex_wb.instr_type = instr_type;
  assign ex_wb.pc         = pc_i;
  assign ex_wb.rf_waddr   = rd_i;
  assign ex_wb.rf_wdata   = alu_result;
  assign ex_wb.rf_we      = rf_we;

  // Memory ops start their LSU access in the same cycle
  assign lsu_req.req   = accept && is_mem;
  assign lsu_req.store = (op_i == OP_SW);
  assign lsu_req.addr  = alu_result;
  assign lsu_req.wdata = op_b;

  // Handing an instruction to a writeback stage that cannot take it would lose it
  a_en_wb_needs_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
    ex_wb.en_wb |-> hz.ready_wb);

  // A memory op held in writeback always has its LSU access still in flight
  a_mem_wb_lsu_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (hz.outstanding_load || hz.outstanding_store) |-> lsu_busy_i);

endmodule

//--- wb_stage.sv
/*
 * Writeback stage holding one instruction, waiting on the LSU for memory ops,
 * selecting the register write source and reporting hazards to execute
 */

`timescale 1ns/1ps

module wb_stage (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  ex_wb_if.wb                              ex_wb,
  wb_hz_if.wb                              hz,
  input  logic [wb_subsys_pkg::XLEN-1:0]   rf_wdata_lsu_i,
  input  logic                             rf_we_lsu_i,
  input  logic                             lsu_resp_valid_i,
  output logic [wb_subsys_pkg::REG_AW-1:0] rf_waddr_o,
  output logic [wb_subsys_pkg::XLEN-1:0]   rf_wdata_o,
  output logic                             rf_we_o,
  output logic [wb_subsys_pkg::XLEN-1:0]   pc_wb_o,
  output logic                             instr_done_o
);
  import wb_subsys_pkg::*;

  logic              wb_valid_q;
  logic              wb_valid_d;
  logic              wb_done;
  wb_instr_type_e    wb_type_q;
  logic [XLEN-1:0]   wb_pc_q;
  logic [REG_AW-1:0] rf_waddr_q;
  logic [XLEN-1:0]   rf_wdata_q;
  logic              rf_we_q;
  logic              we_held;

  // Non-memory ops finish in their first writeback cycle
  // Loads and stores wait for the LSU response strobe
  // Only meaningful while wb_valid_q is set
  assign wb_done = (wb_type_q == WB_INSTR_OTHER) || lsu_resp_valid_i;

  // A new instruction can enter in the same cycle the old one leaves
  assign wb_valid_d = ex_wb.en_wb || (wb_valid_q && !wb_done);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wb_valid_q <= 1'b0;
    end else begin
      wb_valid_q <= wb_valid_d;
    end
  end

  // Payload follows the en_wb strobe and keeps its value while stalled
  always_ff @(posedge clk_i) begin
    if (ex_wb.en_wb) begin
      wb_type_q  <= ex_wb.instr_type;
      wb_pc_q    <= ex_wb.pc;
      rf_waddr_q <= ex_wb.rf_waddr;
      rf_wdata_q <= ex_wb.rf_wdata;
      rf_we_q    <= ex_wb.rf_we;
    end
  end

  // Write request from the result computed in execute
  assign we_held = wb_valid_q && rf_we_q;

  // Execute results and load data share one register file write port
  assign rf_waddr_o = rf_waddr_q;
  assign rf_wdata_o = we_held ? rf_wdata_q : rf_wdata_lsu_i;
  assign rf_we_o    = we_held || rf_we_lsu_i;

  // Done and pc are presented together in the completing cycle
  assign instr_done_o = wb_valid_q && wb_done;
  assign pc_wb_o      = wb_pc_q;

  // Execute may issue once the held instruction finishes this cycle
  assign hz.ready_wb = !wb_valid_q || wb_done;

  // A pending load counts as a register write even though its data is not here yet
  assign hz.rf_write_wb = wb_valid_q && (rf_we_q || (wb_type_q == WB_INSTR_LOAD));
  assign hz.rf_waddr_wb = rf_waddr_q;

  // Only the flopped execute result is forwarded
  // Memory read data arrives too late for the operand path
  assign hz.rf_wdata_fwd = rf_wdata_q;

  assign hz.outstanding_load  = wb_valid_q && (wb_type_q == WB_INSTR_LOAD);
  assign hz.outstanding_store = wb_valid_q && (wb_type_q == WB_INSTR_STORE);

  // Execute and LSU never both claim the write port in one cycle
  a_one_write_source: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({we_held, rf_we_lsu_i}));

endmodule

//--- lsu.sv
/*
 * Load/store unit with a reset-cleared word memory and fixed response delay
 */

`timescale 1ns/1ps

module lsu (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  lsu_req_if.lsu                         lsu_req,
  output logic                           busy_o,
  output logic [wb_subsys_pkg::XLEN-1:0] rf_wdata_lsu_o,
  output logic                           rf_we_lsu_o,
  output logic                           lsu_resp_valid_o
);
  import wb_subsys_pkg::*;

  logic [LSU_CNT_W-1:0] cnt_q;
  logic [LSU_CNT_W-1:0] cnt_d;
  logic                 store_q;
  logic [XLEN-1:0]      addr_q;
  logic [XLEN-1:0]      wdata_q;
  logic [MEM_AW-1:0]    word_idx;
  logic [XLEN-1:0]      mem_q [MEM_WORDS];

  // Word index comes from the address bits above the byte offset and ignores the upper bits
  assign word_idx = addr_q[MEM_AW+1:2];

  // Busy from the accepting edge until the response cycle has passed
  assign busy_o = (cnt_q != '0);

  // The response shows up in the last counted cycle
  assign lsu_resp_valid_o = (cnt_q == LSU_CNT_W'(1));

  // Loads return the addressed word combinationally in the response cycle
  assign rf_wdata_lsu_o = mem_q[word_idx];
  assign rf_we_lsu_o    = lsu_resp_valid_o && !store_q;

  // A new request reloads the counter, otherwise it runs down to zero
  always_comb begin
    cnt_d = cnt_q;
    if (lsu_req.req) begin
      cnt_d = LSU_CNT_W'(LSU_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_d = cnt_q - LSU_CNT_W'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_d;
    end
  end

  // Request payload is captured once and held for the whole access
  always_ff @(posedge clk_i) begin
    if (lsu_req.req) begin
      store_q <= lsu_req.store;
      addr_q  <= lsu_req.addr;
      wdata_q <= lsu_req.wdata;
    end
  end

  // Memory starts out zeroed after reset
  // Stores commit at the edge that ends the response cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem_q[i] <= '0;
      end
    end else if (lsu_resp_valid_o && store_q) begin
      mem_q[word_idx] <= wdata_q;
    end
  end

  // Execute has to hold memory ops back until the previous access is done
  a_no_req_while_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    lsu_req.req |-> !busy_o);

endmodule

//--- regfile.sv
/*
 * 32 by 32-bit register file, two operand read ports and a debug read port
 */

`timescale 1ns/1ps

module regfile (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic [wb_subsys_pkg::REG_AW-1:0] raddr_a_i,
  output logic [wb_subsys_pkg::XLEN-1:0]   rdata_a_o,
  input  logic [wb_subsys_pkg::REG_AW-1:0] raddr_b_i,
  output logic [wb_subsys_pkg::XLEN-1:0]   rdata_b_o,
  input  logic [wb_subsys_pkg::REG_AW-1:0] dbg_raddr_i,
  output logic [wb_subsys_pkg::XLEN-1:0]   dbg_rdata_o,
  input  logic [wb_subsys_pkg::REG_AW-1:0] waddr_i,
  input  logic [wb_subsys_pkg::XLEN-1:0]   wdata_i,
  input  logic                             we_i
);
  import wb_subsys_pkg::*;

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // Writes to x0 are dropped so it reads as zero forever
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // All reads are combinational
  // A same-cycle write is not visible here, so execute relies on forwarding
  assign rdata_a_o   = regs_q[raddr_a_i];
  assign rdata_b_o   = regs_q[raddr_b_i];
  assign dbg_rdata_o = regs_q[dbg_raddr_i];

endmodule

//--- wb_subsys_if.sv
/*
 * Interfaces execute to writeback, execute to LSU and writeback hazard feedback
 */

`timescale 1ns/1ps

// Instruction hand-over from execute into the writeback stage
interface ex_wb_if;
  import wb_subsys_pkg::*;

  // One-cycle strobe that is raised only in a cycle where the instruction is accepted
  logic              en_wb;
  wb_instr_type_e    instr_type;
  logic [XLEN-1:0]   pc;
  logic [REG_AW-1:0] rf_waddr;
  logic [XLEN-1:0]   rf_wdata;
  logic              rf_we;

  modport ex (output en_wb, instr_type, pc, rf_waddr, rf_wdata, rf_we);
  modport wb (input  en_wb, instr_type, pc, rf_waddr, rf_wdata, rf_we);
endinterface

// Load/store request from execute to the LSU
interface lsu_req_if;
  import wb_subsys_pkg::*;

  // One-cycle strobe that is issued only while the LSU is idle
  logic            req;
  logic            store;
  logic [XLEN-1:0] addr;
  logic [XLEN-1:0] wdata;

  modport ex  (output req, store, addr, wdata);
  modport lsu (input  req, store, addr, wdata);
endinterface

// Stall and forwarding information reported back to execute
interface wb_hz_if;
  import wb_subsys_pkg::*;

  logic              ready_wb;
  logic              rf_write_wb;
  logic [REG_AW-1:0] rf_waddr_wb;
  logic [XLEN-1:0]   rf_wdata_fwd;
  logic              outstanding_load;
  logic              outstanding_store;

  modport wb (output ready_wb, rf_write_wb, rf_waddr_wb, rf_wdata_fwd,
                     outstanding_load, outstanding_store);
  modport ex (input  ready_wb, rf_write_wb, rf_waddr_wb, rf_wdata_fwd,
                     outstanding_load, outstanding_store);
endinterface

//--- wb_subsys_pkg.sv
/*
 * Shared opcode and writeback-type enums, plus the size and latency
 * localparams of the writeback subsystem
 */

package wb_subsys_pkg;

  // Data path width of the integer pipeline
  localparam int unsigned XLEN = 32;

  // Register file addressing with 5 bits for x0 to x31
  localparam int unsigned REG_AW   = 5;
  localparam int unsigned NUM_REGS = 2 ** REG_AW;

  // LSU data memory, word addressed through address bits 5 to 2
  localparam int unsigned MEM_WORDS = 16;
  localparam int unsigned MEM_AW    = $clog2(MEM_WORDS);

  // Cycles from an accepted LSU request to its response strobe
  localparam int unsigned LSU_LATENCY = 2;
  // Counter width must hold the full latency value
  localparam int unsigned LSU_CNT_W   = $clog2(LSU_LATENCY + 1);

  // Already decoded operations accepted by the issue stage
  typedef enum logic [2:0] {
    OP_ADD  = 3'd0,
    OP_SUB  = 3'd1,
    OP_AND  = 3'd2,
    OP_OR   = 3'd3,
    OP_XOR  = 3'd4,
    OP_ADDI = 3'd5,
    OP_LW   = 3'd6,
    OP_SW   = 3'd7
  } op_e;

  // Tells writeback whether completion has to wait for the LSU
  typedef enum logic [1:0] {
    WB_INSTR_LOAD  = 2'd0,
    WB_INSTR_STORE = 2'd1,
    WB_INSTR_OTHER = 2'd2
  } wb_instr_type_e;

endpackage
